//--- verif/stream_stimulus.txt
// Columns in hex: test port tdata tuser tkeep tlast
// A record with test 0 closes the list
1 2 a0000001 1 f 0
1 2 a0000002 2 f 0
1 2 a0000003 3 3 1
2 0 b0000001 0 f 0
2 0 b0000002 1 f 1
2 0 b0000003 2 1 1
2 1 b1000001 3 f 0
2 1 b1000002 4 f 1
2 1 b1000003 5 3 1
2 2 b2000001 6 f 0
2 2 b2000002 7 f 1
2 2 b2000003 8 7 1
2 3 b3000001 9 f 0
2 3 b3000002 a f 1
2 3 b3000003 b f 1
3 1 c1000000 0 f 0
3 1 c1000001 1 f 0
3 1 c1000002 2 f 0
3 1 c1000003 3 f 0
3 1 c1000004 4 f 0
3 1 c1000005 5 f 0
3 1 c1000006 6 f 0
3 1 c1000007 7 f 0
3 1 c1000008 8 f 0
3 1 c1000009 9 f 0
3 1 c100000a a f 0
3 1 c100000b b f 0
3 1 c100000c c f 0
3 1 c100000d d f 0
3 1 c100000e e f 0
3 1 c100000f f f 0
3 1 c1000010 0 7 1
4 0 d0000001 1 f 0
4 0 d0000002 2 f 0
4 0 d0000003 3 1 1
4 3 d3000001 4 f 0
4 3 d3000002 5 3 1
4 3 d3000003 6 f 1
4 2 d2000001 7 f 0
4 2 d2000002 8 7 1
0 0 0 0 0 0

//--- stream_mux.f
src/stream_pkg.sv
src/stream_fifo_mem.sv
src/stream_fifo.sv
src/stream_arbiter.sv
src/stream_mux_top.sv
verif/stream_mux_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the stream concentrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	--top-module stream_mux_tb \
	-f stream_mux.f \
	-o stream_mux_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/stream_mux_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# Pass only when the testbench reported a clean run
if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "Simulation reported failures"
exit 1

//--- verif/stream_mux_tb.sv
`default_nettype none

module stream_mux_tb
	import stream_pkg::*;
();

	localparam int FIFO_DEPTH      = 16;
	localparam int NUM_PORTS       = 4;
	localparam int ADDR_BITS       = $clog2(FIFO_DEPTH);
	localparam int IDX_BITS        = $clog2(NUM_PORTS);
	localparam int MAX_RECS        = 64;
	localparam int CYCLES_PER_BEAT = 40;

	// Tests with a special egress behavior
	localparam int ROTATE_TEST = 2;
	localparam int HOLD_TEST   = 3;
	localparam int RANDOM_TEST = 4;

	// Egress ready modes
	localparam int READY_ON     = 0;
	localparam int READY_HOLD   = 1;
	localparam int READY_RANDOM = 2;

	logic                              axi_tx;
	logic                              reset;
	stream_beat_t [NUM_PORTS-1:0]      in_beat;
	logic [NUM_PORTS-1:0]              in_valid;
	logic [NUM_PORTS-1:0]              in_ready;
	logic [NUM_PORTS-1:0][ADDR_BITS:0] wr_size;
	stream_beat_t                      out_beat;
	logic [IDX_BITS-1:0]               out_src;
	logic                              out_valid;
	logic                              out_ready;

	stream_mux_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.NUM_PORTS(NUM_PORTS)
	) u_stream_mux_top (
		.axi_tx(axi_tx),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.wr_size(wr_size),
		.out_beat(out_beat),
		.out_src(out_src),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	////////////////////
	// Stimulus and scoreboards

	// Six words per record
	logic [31:0]  stim_mem [6*MAX_RECS];
	int           rec_test [MAX_RECS];
	int           rec_port [MAX_RECS];
	stream_beat_t rec_beat [MAX_RECS];
	int           num_recs;
	int           last_test_num;

	// Beats still to offer and beats awaiting egress
	stream_beat_t drv_q [NUM_PORTS][$];
	stream_beat_t exp_q [NUM_PORTS][$];

	int   errors;
	int   cycles;
	int   cycle_limit;
	int   ready_mode;
	int   cur_test;
	// Packet tracking at egress
	int   next_turn;
	int   pkt_src;
	logic in_pkt;

	task automatic compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	function automatic int outstanding_beats();
		int total;
		total = 0;
		for (int p = 0; p < NUM_PORTS; p++)
			total += drv_q[p].size() + exp_q[p].size();
		return total;
	endfunction

	// Round-robin turn among ports that still owe beats
	function automatic int next_granted_port();
		int port;
		for (int i = 0; i < NUM_PORTS; i++) begin
			port = (next_turn + i) % NUM_PORTS;
			if (exp_q[port].size() > 0)
				return port;
		end
		return next_turn;
	endfunction

	function automatic string test_label(input int num);
		case (num)
			1:       return "single port packet";
			2:       return "all ports, round robin";
			3:       return "egress held, FIFO fills";
			4:       return "random egress ready";
			default: return "extra beats";
		endcase
	endfunction

	// Record columns are test, port, tdata, tuser, tkeep and tlast
	task automatic load_stimulus();
		int base;
		$readmemh("verif/stream_stimulus.txt", stim_mem);
		num_recs      = 0;
		last_test_num = 0;
		for (int i = 0; i < MAX_RECS; i++) begin
			base = 6 * i;
			// Test zero closes the list
			if (stim_mem[base] == 32'd0)
				break;
			rec_test[i]       = int'(stim_mem[base]);
			rec_port[i]       = int'(stim_mem[base + 1]);
			rec_beat[i].tdata = stim_mem[base + 2];
			rec_beat[i].tuser = stim_mem[base + 3][USER_WIDTH-1:0];
			rec_beat[i].tkeep = stim_mem[base + 4][KEEP_WIDTH-1:0];
			rec_beat[i].tlast = stim_mem[base + 5][0];
			if (rec_test[i] > last_test_num)
				last_test_num = rec_test[i];
			num_recs++;
		end
	endtask

	// Checks run away from both edges
	task automatic wait_for_stall(input int port);
		while (!(in_valid[port] && !in_ready[port])) begin
			@(posedge axi_tx);
			#2;
		end
	endtask

	task automatic wait_for_drain();
		while (outstanding_beats() != 0) begin
			@(posedge axi_tx);
			#2;
		end
	endtask

	////////////////////
	// Clock and drivers

	initial begin
		axi_tx = 1'b0;
		forever #4 axi_tx = ~axi_tx;
	end

	// Head of each port queue held until taken
	always @(posedge axi_tx) begin
		#1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (!reset && drv_q[p].size() > 0) begin
				in_beat[p]  = drv_q[p][0];
				in_valid[p] = 1'b1;
			end else begin
				in_valid[p] = 1'b0;
			end
		end
		case (ready_mode)
			READY_HOLD:   out_ready = 1'b0;
			READY_RANDOM: out_ready = ($urandom % 3) != 0;
			default:      out_ready = 1'b1;
		endcase
	end

	////////////////////
	// Handshake monitor

	// Mid-cycle sample ahead of the transfer edge
	always @(negedge axi_tx) begin : monitor
		stream_beat_t exp_beat;
		int src;
		int exp_src;
		if (!reset) begin
			if (out_valid && out_ready) begin
				src = int'(out_src);
				if (!in_pkt) begin
					// Packet start takes the next turn in rotation
					exp_src = next_granted_port();
					if (cur_test == ROTATE_TEST)
						compare_value("out_src", 64'(exp_src), 64'(src));
					next_turn = (exp_src + 1) % NUM_PORTS;
					pkt_src   = src;
				end else if (src != pkt_src) begin
					$display("Packet from port %0d was interleaved by port %0d", pkt_src, src);
					errors++;
				end
				in_pkt = !out_beat.tlast;
				if (exp_q[src].size() == 0) begin
					$display("Beat from port %0d arrived with nothing queued", src);
					errors++;
				end else begin
					exp_beat = exp_q[src].pop_front();
					compare_value("out_beat.tdata", 64'(exp_beat.tdata), 64'(out_beat.tdata));
					compare_value("out_beat.tuser", 64'(exp_beat.tuser), 64'(out_beat.tuser));
					compare_value("out_beat.tkeep", 64'(exp_beat.tkeep), 64'(out_beat.tkeep));
					compare_value("out_beat.tlast", 64'(exp_beat.tlast), 64'(out_beat.tlast));
				end
			end
			// Ingress beats move to the scoreboard
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (in_valid[p] && in_ready[p]) begin
					exp_q[p].push_back(in_beat[p]);
					void'(drv_q[p].pop_front());
				end
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge axi_tx);
			cycles++;
		end
		$display("Run timed out after %0d cycles with %0d beats still outstanding",
			cycles, outstanding_beats());
		$display("ERRORS FOUND");
		$finish;
	end

	////////////////////
	// Test sequence

	initial begin : main
		int hold_port;
		int test_errors;
		int test_beats;
		int tests_run;
		void'($urandom(32));
		reset      = 1'b1;
		in_beat    = '0;
		in_valid   = '0;
		out_ready  = 1'b0;
		ready_mode = READY_ON;
		errors     = 0;
		cur_test   = 0;
		next_turn  = 0;
		pkt_src    = 0;
		in_pkt     = 1'b0;
		tests_run  = 0;
		load_stimulus();
		cycle_limit = CYCLES_PER_BEAT * num_recs;

		repeat (4) @(posedge axi_tx);
		#2;
		reset = 1'b0;
		@(posedge axi_tx);
		#2;

		// Idle state after reset
		test_errors = errors;
		compare_value("out_valid", 64'(0), 64'(out_valid));
		for (int p = 0; p < NUM_PORTS; p++) begin
			compare_value($sformatf("in_ready[%0d]", p), 64'(1), 64'(in_ready[p]));
			compare_value($sformatf("wr_size[%0d]", p), 64'(FIFO_DEPTH), 64'(wr_size[p]));
		end
		tests_run++;
		$display("Test 0 (reset state): %s", (errors == test_errors) ? "passed" : "failed");

		for (int t = 1; t <= last_test_num; t++) begin
			test_errors = errors;
			test_beats  = 0;
			hold_port   = -1;
			cur_test    = t;
			for (int i = 0; i < num_recs; i++) begin
				if (rec_test[i] == t) begin
					drv_q[rec_port[i]].push_back(rec_beat[i]);
					test_beats++;
					if (hold_port < 0)
						hold_port = rec_port[i];
				end
			end
			if (t == HOLD_TEST)
				ready_mode = READY_HOLD;
			else if (t == RANDOM_TEST)
				ready_mode = READY_RANDOM;
			else
				ready_mode = READY_ON;

			if (t == HOLD_TEST && hold_port >= 0) begin
				// Port stalls once one slot is left
				wait_for_stall(hold_port);
				compare_value($sformatf("wr_size[%0d]", hold_port), 64'(1),
					64'(wr_size[hold_port]));
				// Buffer plus the beat on deck
				compare_value("accepted beats", 64'(FIFO_DEPTH),
					64'(exp_q[hold_port].size()));
				ready_mode = READY_ON;
			end
			wait_for_drain();
			tests_run++;
			$display("Test %0d (%s): %0d beats, %s", t, test_label(t), test_beats,
				(errors == test_errors) ? "passed" : "failed");
		end

		ready_mode = READY_ON;
		$display("Tests run: %0d, beats: %0d, errors: %0d", tests_run, num_recs, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/stream_mux_top.sv
`default_nettype none

module stream_mux_top import stream_pkg::*; #(
	parameter int FIFO_DEPTH = 16,
	parameter int NUM_PORTS  = 4,

	localparam int ADDR_BITS = $clog2(FIFO_DEPTH),
	localparam int IDX_BITS  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
)(
	input  logic                                axi_tx,
	input  logic                                reset,

	// Ingress ports
	input  stream_beat_t [NUM_PORTS-1:0]        in_beat,
	input  logic         [NUM_PORTS-1:0]        in_valid,
	output logic         [NUM_PORTS-1:0]        in_ready,

	// Free entries per port
	output logic [NUM_PORTS-1:0][ADDR_BITS:0]   wr_size,

	// Concentrated egress
	output stream_beat_t                        out_beat,
	output logic         [IDX_BITS-1:0]         out_src,
	output logic                                out_valid,
	input  logic                                out_ready
);

	////////////////////
	// Per-port FIFOs

	stream_beat_t [NUM_PORTS-1:0] fifo_beat;
	logic         [NUM_PORTS-1:0] fifo_valid;
	logic         [NUM_PORTS-1:0] fifo_ready;

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		stream_fifo #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_fifo (
			.axi_tx(axi_tx),
			.reset(reset),
			.in_beat(in_beat[p]),
			.in_valid(in_valid[p]),
			.in_ready(in_ready[p]),
			.out_beat(fifo_beat[p]),
			.out_valid(fifo_valid[p]),
			.out_ready(fifo_ready[p]),
			.wr_size(wr_size[p])
		);
	end

	////////////////////
	// Packet arbiter

	// One FIFO owns the egress per packet
	stream_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) u_arbiter (
		.axi_tx(axi_tx),
		.reset(reset),
		.req_beat(fifo_beat),
		.req_valid(fifo_valid),
		.req_ready(fifo_ready),
		.out_beat(out_beat),
		.out_src(out_src),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

//--- src/stream_arbiter.sv
`default_nettype none

module stream_arbiter import stream_pkg::*; #(
	parameter int NUM_PORTS = 4,

	localparam int IDX_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
)(
	input  logic                           axi_tx,
	input  logic                           reset,

	// Requesting FIFO outputs
	input  stream_beat_t [NUM_PORTS-1:0]   req_beat,
	input  logic         [NUM_PORTS-1:0]   req_valid,
	output logic         [NUM_PORTS-1:0]   req_ready,

	// Shared egress
	output stream_beat_t                   out_beat,
	output logic         [IDX_BITS-1:0]    out_src,
	output logic                           out_valid,
	input  logic                           out_ready
);

	// Highest port index
	localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(NUM_PORTS - 1);

	////////////////////
	// Arbiter state

	arb_state_t          state;
	logic [IDX_BITS-1:0] grant_idx;
	// Port first in turn for the next grant
	logic [IDX_BITS-1:0] rr_ptr;

	logic                pick_found;
	logic [IDX_BITS-1:0] pick_idx;
	logic                last_xfer;

	////////////////////
	// Round-robin pick

	// Scan from rr_ptr upward with wrap
	// Loop runs downward so the nearest valid port wins
	always_comb begin : pick_next
		int cand;
		pick_found = 1'b0;
		pick_idx   = '0;
		for (int i = NUM_PORTS - 1; i >= 0; i--) begin
			cand = (int'(rr_ptr) + i) % NUM_PORTS;
			if (req_valid[cand]) begin
				pick_found = 1'b1;
				pick_idx   = IDX_BITS'(cand);
			end
		end
	end

	// Packet ends when its tlast beat transfers
	assign last_xfer = out_valid && out_ready && out_beat.tlast;

	always_ff @(posedge axi_tx) begin
		if (reset) begin
			state     <= ARB_IDLE;
			grant_idx <= '0;
			rr_ptr    <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Lock onto the chosen port
					if (pick_found) begin
						state     <= ARB_PACKET;
						grant_idx <= pick_idx;
						// Next turn goes to the following port
						if (pick_idx == LAST_IDX)
							rr_ptr <= '0;
						else
							rr_ptr <= pick_idx + 1'b1;
					end
				end
				ARB_PACKET: begin
					// Release after the last beat
					if (last_xfer)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	////////////////////
	// Egress steering

	assign out_beat  = req_beat[grant_idx];
	assign out_src   = grant_idx;
	assign out_valid = (state == ARB_PACKET) && req_valid[grant_idx];

	// Ready back to the granted port only
	always_comb begin
		req_ready = '0;
		if (state == ARB_PACKET)
			req_ready[grant_idx] = out_ready;
	end

endmodule

`default_nettype wire

//--- src/stream_fifo.sv
`default_nettype none

module stream_fifo import stream_pkg::*; #(
	parameter int FIFO_DEPTH = 16,

	localparam int ADDR_BITS = $clog2(FIFO_DEPTH)
)(
	input  logic               axi_tx,
	input  logic               reset,

	// Ingress stream
	input  stream_beat_t       in_beat,
	input  logic               in_valid,
	output logic               in_ready,

	// Egress stream
	output stream_beat_t       out_beat,
	output logic               out_valid,
	input  logic               out_ready,

	// Free entries
	output logic [ADDR_BITS:0] wr_size
);

	////////////////////
	// Buffer

	logic               push;
	logic               rd_en;
	logic [ADDR_BITS:0] rd_size;
	stream_beat_t       rd_data;

	// Push on every ingress handshake
	assign push = in_valid && in_ready;

	stream_fifo_mem #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_mem (
		.axi_tx(axi_tx),
		.reset(reset),
		.wr(push),
		.din(in_beat),
		.rd(rd_en),
		.dout(rd_data),
		.wsize(wr_size),
		.rsize(rd_size)
	);

	// Keep one slot spare for a beat in flight
	assign in_ready = (wr_size > 1);

	////////////////////
	// Pop control

	always_comb begin
		rd_en = 1'b0;
		// Need stored data first
		// Then pop if nothing on deck or current beat leaves
		if ((rd_size != '0) && (out_ready || !out_valid))
			rd_en = 1'b1;
	end

	// Output valid register
	always_ff @(posedge axi_tx) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			// Clear on acceptance
			if (out_ready)
				out_valid <= 1'b0;
			// Fresh pop wins
			if (rd_en)
				out_valid <= 1'b1;
		end
	end

	// Beat from read register, tlast only while valid
	always_comb begin
		out_beat       = rd_data;
		out_beat.tlast = rd_data.tlast && out_valid;
	end

endmodule

`default_nettype wire

//--- src/stream_fifo_mem.sv
`default_nettype none

module stream_fifo_mem import stream_pkg::*; #(
	parameter int FIFO_DEPTH = 16,

	localparam int ADDR_BITS = $clog2(FIFO_DEPTH)
)(
	input  logic               axi_tx,
	input  logic               reset,

	// Write side
	input  logic               wr,
	input  stream_beat_t       din,

	// Read side
	input  logic               rd,
	output stream_beat_t       dout,

	// Fill status
	output logic [ADDR_BITS:0] wsize,
	output logic [ADDR_BITS:0] rsize
);

	// Entry count of a full buffer
	localparam logic [ADDR_BITS:0] FULL_COUNT = (ADDR_BITS + 1)'(FIFO_DEPTH);

	////////////////////
	// Storage

	// Beat array, no reset on payload
	stream_beat_t mem [FIFO_DEPTH];

	// Pointers carry one extra wrap bit
	logic [ADDR_BITS:0] wr_ptr;
	logic [ADDR_BITS:0] rd_ptr;

	// Address part of each pointer
	logic [ADDR_BITS-1:0] wr_addr;
	logic [ADDR_BITS-1:0] rd_addr;

	assign wr_addr = wr_ptr[ADDR_BITS-1:0];
	assign rd_addr = rd_ptr[ADDR_BITS-1:0];

	////////////////////
	// Pointer update

	always_ff @(posedge axi_tx) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Advance on each strobe
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////
	// Data path

	// Store beat at the write address
	always_ff @(posedge axi_tx) begin
		if (wr)
			mem[wr_addr] <= din;
	end

	// Registered read, data valid one edge after the strobe
	always_ff @(posedge axi_tx) begin
		if (rd)
			dout <= mem[rd_addr];
	end

	////////////////////
	// Fill counters

	// Stored entries from pointer distance
	// Wrap bit keeps full apart from empty
	assign rsize = wr_ptr - rd_ptr;

	// Free entries are the rest
	assign wsize = FULL_COUNT - rsize;

endmodule

`default_nettype wire

//--- src/stream_pkg.sv
`default_nettype none

package stream_pkg;

	////////////////////
	// Beat widths

	// Payload width in bits
	localparam int DATA_WIDTH = 32;

	// Sideband user bits
	localparam int USER_WIDTH = 4;

	// One keep bit per payload byte
	localparam int KEEP_WIDTH = DATA_WIDTH / 8;

	////////////////////
	// Beat word

	// One stream beat, also the FIFO storage word
	typedef struct packed {
		logic [DATA_WIDTH-1:0] tdata;
		logic [USER_WIDTH-1:0] tuser;
		logic [KEEP_WIDTH-1:0] tkeep;
		logic                  tlast;
	} stream_beat_t;

	////////////////////
	// Arbiter states

	// Idle means no grant is held
	// Packet means the grant is locked until tlast
	typedef enum logic {
		ARB_IDLE   = 1'b0,
		ARB_PACKET = 1'b1
	} arb_state_t;

endpackage

`default_nettype wire
